/* rtl/cla_macros.svh */
`ifndef CLA_MACROS_SVH
`define CLA_MACROS_SVH

// Datapath and bus widths
`define CLA_DATA_W   32
`define CLA_GROUP_W  4
`define CLA_ADDR_W   8

// Register map
`define CLA_REG_OP_A    8'h00
`define CLA_REG_OP_B    8'h04
`define CLA_REG_CMD     8'h08
`define CLA_REG_RESULT  8'h0C
`define CLA_REG_FLAGS   8'h10

// Bit positions inside CMD and FLAGS
`define CLA_CMD_SUB_BIT    0
`define CLA_CMD_CIN_BIT    1
`define CLA_FLAG_COUT_BIT  0
`define CLA_FLAG_OVF_BIT   1
`define CLA_FLAG_DONE_BIT  2

`endif

/* rtl/cla_pkg.sv */
`include "cla_macros.svh"

package cla_pkg;

    // Operand or sum word
    typedef logic [`CLA_DATA_W-1:0] data_t;

    // One lookahead group slice
    typedef logic [`CLA_GROUP_W-1:0] group_t;

    typedef logic [`CLA_ADDR_W-1:0] apb_addr_t;

    // Operands already conditioned for add or subtract
    typedef struct packed {
        data_t a;
        data_t b;
        logic  cin;
    } add_req_t;

    typedef struct packed {
        data_t sum;
        logic  cout;
        logic  overflow;
    } add_rsp_t;

endpackage

/* rtl/cla4.sv */
`timescale 1ns/1ps

module cla4 (
    input  cla_pkg::group_t a,
    input  cla_pkg::group_t b,
    input  logic            cin,
    output cla_pkg::group_t sum,
    output logic            gg,
    output logic            pg
);
    import cla_pkg::*;

    group_t g;
    group_t p;
    group_t c;

    // Per-bit generate and propagate
    assign g = a & b;
    assign p = a ^ b;

    // Each carry straight from cin, no ripple
    assign c[0] = cin;
    assign c[1] = g[0]
                | (p[0] & cin);
    assign c[2] = g[1]
                | (p[1] & g[0])
                | (p[1] & p[0] & cin);
    assign c[3] = g[2]
                | (p[2] & g[1])
                | (p[2] & p[1] & g[0])
                | (p[2] & p[1] & p[0] & cin);

    assign sum = p ^ c;

    // Group signals for the next level up
    assign gg = g[3]
              | (p[3] & g[2])
              | (p[3] & p[2] & g[1])
              | (p[3] & p[2] & p[1] & g[0]);
    assign pg = &p;

endmodule

/* rtl/cla16.sv */
`timescale 1ns/1ps
`include "cla_macros.svh"

module cla16 (
    input  logic [15:0] a,
    input  logic [15:0] b,
    input  logic        cin,
    output logic [15:0] sum,
    output logic        gg,
    output logic        pg
);

    logic [3:0] grp_g;
    logic [3:0] grp_p;
    logic [3:0] grp_c;

    // Second-level lookahead across the four groups
    assign grp_c[0] = cin;
    assign grp_c[1] = grp_g[0]
                    | (grp_p[0] & cin);
    assign grp_c[2] = grp_g[1]
                    | (grp_p[1] & grp_g[0])
                    | (grp_p[1] & grp_p[0] & cin);
    assign grp_c[3] = grp_g[2]
                    | (grp_p[2] & grp_g[1])
                    | (grp_p[2] & grp_p[1] & grp_g[0])
                    | (grp_p[2] & grp_p[1] & grp_p[0] & cin);

    for (genvar i = 0; i < 4; i++) begin : g_grp
        cla4 u_cla4 (
            .a   (a[i*`CLA_GROUP_W +: `CLA_GROUP_W]),
            .b   (b[i*`CLA_GROUP_W +: `CLA_GROUP_W]),
            .cin (grp_c[i]),
            .sum (sum[i*`CLA_GROUP_W +: `CLA_GROUP_W]),
            .gg  (grp_g[i]),
            .pg  (grp_p[i])
        );
    end

    // 16-bit block generate and propagate
    assign gg = grp_g[3]
              | (grp_p[3] & grp_g[2])
              | (grp_p[3] & grp_p[2] & grp_g[1])
              | (grp_p[3] & grp_p[2] & grp_p[1] & grp_g[0]);
    assign pg = &grp_p;

endmodule

/* rtl/cla32.sv */
`timescale 1ns/1ps
`include "cla_macros.svh"

module cla32 (
    input  cla_pkg::add_req_t req,
    output cla_pkg::add_rsp_t rsp
);
    import cla_pkg::*;

    localparam int HALF_W = `CLA_DATA_W / 2;

    data_t sum;
    logic  lo_gg;
    logic  lo_pg;
    logic  hi_gg;
    logic  hi_pg;
    logic  c_half;

    cla16 u_cla16_lo (
        .a   (req.a[HALF_W-1:0]),
        .b   (req.b[HALF_W-1:0]),
        .cin (req.cin),
        .sum (sum[HALF_W-1:0]),
        .gg  (lo_gg),
        .pg  (lo_pg)
    );

    // Carry into the upper half
    assign c_half = lo_gg | (lo_pg & req.cin);

    cla16 u_cla16_hi (
        .a   (req.a[`CLA_DATA_W-1:HALF_W]),
        .b   (req.b[`CLA_DATA_W-1:HALF_W]),
        .cin (c_half),
        .sum (sum[`CLA_DATA_W-1:HALF_W]),
        .gg  (hi_gg),
        .pg  (hi_pg)
    );

    assign rsp.sum  = sum;
    assign rsp.cout = hi_gg | (hi_pg & lo_gg) | (hi_pg & lo_pg & req.cin);

    // Same-sign operands with a result of the other sign
    assign rsp.overflow = (req.a[`CLA_DATA_W-1] == req.b[`CLA_DATA_W-1])
                        & (sum[`CLA_DATA_W-1] != req.a[`CLA_DATA_W-1]);

endmodule

/* rtl/adder_apb_regs.sv */
`timescale 1ns/1ps
`include "cla_macros.svh"

module adder_apb_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  cla_pkg::apb_addr_t paddr,
    input  cla_pkg::data_t     pwdata,
    output cla_pkg::data_t     prdata,
    output logic               pready,
    output logic               pslverr,
    output cla_pkg::add_req_t  req,
    input  cla_pkg::add_rsp_t  rsp
);
    import cla_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_CAPTURE
    } cap_state_t;

    cap_state_t state_q;
    cap_state_t state_d;

    data_t    op_a_q;
    data_t    op_b_q;
    logic     sub_q;
    logic     cin_q;
    add_rsp_t rsp_q;
    logic     done_q;

    logic access;
    logic mapped;
    logic ro_reg;
    logic wr_ok;
    logic wr_op_a;
    logic wr_op_b;
    logic wr_cmd;

    // Address decode
    always_comb begin
        mapped = 1'b1;
        ro_reg = 1'b0;
        case (paddr)
            `CLA_REG_OP_A,
            `CLA_REG_OP_B,
            `CLA_REG_CMD:    ro_reg = 1'b0;
            `CLA_REG_RESULT,
            `CLA_REG_FLAGS:  ro_reg = 1'b1;
            default:         mapped = 1'b0;
        endcase
    end

    assign access  = psel & penable;
    assign pready  = 1'b1;
    assign pslverr = access & (!mapped | (pwrite & ro_reg));

    // Only legal writes complete with an effect
    assign wr_ok   = access & pwrite & mapped & !ro_reg;
    assign wr_op_a = wr_ok & (paddr == `CLA_REG_OP_A);
    assign wr_op_b = wr_ok & (paddr == `CLA_REG_OP_B);
    assign wr_cmd  = wr_ok & (paddr == `CLA_REG_CMD);

    // Read mux, CMD and unmapped offsets return zero
    always_comb begin
        prdata = '0;
        case (paddr)
            `CLA_REG_OP_A:   prdata = op_a_q;
            `CLA_REG_OP_B:   prdata = op_b_q;
            `CLA_REG_RESULT: prdata = rsp_q.sum;
            `CLA_REG_FLAGS: begin
                prdata[`CLA_FLAG_COUT_BIT] = rsp_q.cout;
                prdata[`CLA_FLAG_OVF_BIT]  = rsp_q.overflow;
                prdata[`CLA_FLAG_DONE_BIT] = done_q;
            end
            default:         prdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_a_q <= '0;
            op_b_q <= '0;
            sub_q  <= 1'b0;
            cin_q  <= 1'b0;
        end else begin
            if (wr_op_a) begin
                op_a_q <= pwdata;
            end
            if (wr_op_b) begin
                op_b_q <= pwdata;
            end
            if (wr_cmd) begin
                sub_q <= pwdata[`CLA_CMD_SUB_BIT];
                cin_q <= pwdata[`CLA_CMD_CIN_BIT];
            end
        end
    end

    // Subtract is a + ~b + 1, cin bit ignored
    assign req.a   = op_a_q;
    assign req.b   = sub_q ? ~op_b_q : op_b_q;
    assign req.cin = sub_q | cin_q;

    // Capture sequence
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (wr_cmd) begin
                    state_d = ST_CAPTURE;
                end
            end
            ST_CAPTURE: state_d = ST_IDLE;
            default:    state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            rsp_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (wr_op_a | wr_op_b | wr_cmd) begin
                done_q <= 1'b0;
            end
            // Adder output settled one cycle after the command
            if (state_q == ST_CAPTURE) begin
                rsp_q  <= rsp;
                done_q <= 1'b1;
            end
        end
    end

endmodule

/* rtl/adder_apb_top.sv */
`timescale 1ns/1ps

module adder_apb_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  cla_pkg::apb_addr_t paddr,
    input  cla_pkg::data_t     pwdata,
    output cla_pkg::data_t     prdata,
    output logic               pready,
    output logic               pslverr
);
    import cla_pkg::*;

    add_req_t add_req;
    add_rsp_t add_rsp;

    adder_apb_regs u_adder_apb_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .req     (add_req),
        .rsp     (add_rsp)
    );

    // Purely combinational adder
    cla32 u_cla32 (
        .req (add_req),
        .rsp (add_rsp)
    );

endmodule

/* verif/tb_adder_apb.sv */
`timescale 1ns/1ps
`include "cla_macros.svh"

module tb_adder_apb;
    import cla_pkg::*;

    localparam int NUM_RAND    = 300;
    localparam int NUM_OPS     = 2 * NUM_RAND + 40;
    localparam int CYCLE_LIMIT = 20 * NUM_OPS + 100;

    logic      clk;
    logic      rst_n;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    data_t     pwdata;
    data_t     prdata;
    logic      pready;
    logic      pslverr;

    int        cycles = 0;

    // What RESULT and FLAGS should hold right now
    data_t     exp_sum;
    logic      exp_cout;
    logic      exp_ovf;
    logic      exp_done;

    adder_apb_top u_adder_apb_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic check_data(input string sig, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("error: time %0t %s expected 0x%08h actual 0x%08h",
                     $time, sig, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string sig, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error: time %0t %s expected %b actual %b", $time, sig, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_err(input string sig, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error: time %0t %s expected %b actual %b", $time, sig, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // Both tasks start just after a rising edge and return just after one
    task automatic apb_write(input apb_addr_t addr, input data_t data, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #20;
        err = pslverr;
        check_flag("pready", 1'b1, pready);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output data_t data, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #20;
        data = prdata;
        err  = pslverr;
        check_flag("pready", 1'b1, pready);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Reference sum over 33 bits of a, effective b and effective carry-in
    task automatic predict(input data_t a, input data_t b, input logic sub, input logic cin);
        data_t                b_eff;
        logic                 cin_eff;
        logic [`CLA_DATA_W:0] full;
        b_eff    = sub ? ~b : b;
        cin_eff  = sub ? 1'b1 : cin;
        full     = {1'b0, a} + {1'b0, b_eff} + {{`CLA_DATA_W{1'b0}}, cin_eff};
        exp_sum  = full[`CLA_DATA_W-1:0];
        exp_cout = full[`CLA_DATA_W];
        exp_ovf  = (a[`CLA_DATA_W-1] == b_eff[`CLA_DATA_W-1])
                && (exp_sum[`CLA_DATA_W-1] != a[`CLA_DATA_W-1]);
        exp_done = 1'b1;
    endtask

    task automatic check_results();
        data_t rd;
        logic  err;
        apb_read(`CLA_REG_FLAGS, rd, err);
        check_err("pslverr", 1'b0, err);
        check_flag("FLAGS.done", exp_done, rd[`CLA_FLAG_DONE_BIT]);
        check_flag("FLAGS.cout", exp_cout, rd[`CLA_FLAG_COUT_BIT]);
        check_flag("FLAGS.overflow", exp_ovf, rd[`CLA_FLAG_OVF_BIT]);
        check_data("FLAGS.unused", '0, rd & ~data_t'(32'h7));
        apb_read(`CLA_REG_RESULT, rd, err);
        check_err("pslverr", 1'b0, err);
        check_data("RESULT", exp_sum, rd);
    endtask

    task automatic run_op(input data_t a, input data_t b, input logic sub, input logic cin);
        data_t cmd;
        logic  err;
        cmd                   = '0;
        cmd[`CLA_CMD_SUB_BIT] = sub;
        cmd[`CLA_CMD_CIN_BIT] = cin;
        apb_write(`CLA_REG_OP_A, a, err);
        check_err("pslverr", 1'b0, err);
        apb_write(`CLA_REG_OP_B, b, err);
        check_err("pslverr", 1'b0, err);
        apb_write(`CLA_REG_CMD, cmd, err);
        check_err("pslverr", 1'b0, err);
        predict(a, b, sub, cin);
        // Read right after the command completes
        check_results();
    endtask

    task automatic run_random(input logic sub);
        data_t a;
        data_t b;
        data_t r;
        for (int i = 0; i < NUM_RAND; i++) begin
            a = $urandom();
            b = $urandom();
            r = $urandom();
            run_op(a, b, sub, r[0]);
        end
    endtask

    task automatic check_operands();
        data_t val;
        data_t rd;
        logic  err;
        for (int i = 0; i < 4; i++) begin
            run_op($urandom(), $urandom(), 1'b0, 1'b0);
            val = $urandom();
            if (i % 2 == 0) begin
                apb_write(`CLA_REG_OP_A, val, err);
            end else begin
                apb_write(`CLA_REG_OP_B, val, err);
            end
            check_err("pslverr", 1'b0, err);
            exp_done = 1'b0;
            check_results();
            if (i % 2 == 0) begin
                apb_read(`CLA_REG_OP_A, rd, err);
                check_data("OP_A", val, rd);
            end else begin
                apb_read(`CLA_REG_OP_B, rd, err);
                check_data("OP_B", val, rd);
            end
            check_err("pslverr", 1'b0, err);
        end
    endtask

    task automatic check_bus_errors();
        apb_addr_t bad[4] = '{8'h14, 8'h20, 8'h02, 8'hFC};
        data_t     rd;
        data_t     flags_wr;
        logic      err;
        run_op($urandom(), $urandom(), 1'b1, 1'b0);
        foreach (bad[i]) begin
            apb_read(bad[i], rd, err);
            check_err("pslverr", 1'b1, err);
            check_data("PRDATA", '0, rd);
        end
        apb_write(8'h18, $urandom(), err);
        check_err("pslverr", 1'b1, err);
        // Every bit differs from what the registers hold
        apb_write(`CLA_REG_RESULT, ~exp_sum, err);
        check_err("pslverr", 1'b1, err);
        flags_wr                     = '1;
        flags_wr[`CLA_FLAG_COUT_BIT] = !exp_cout;
        flags_wr[`CLA_FLAG_OVF_BIT]  = !exp_ovf;
        flags_wr[`CLA_FLAG_DONE_BIT] = !exp_done;
        apb_write(`CLA_REG_FLAGS, flags_wr, err);
        check_err("pslverr", 1'b1, err);
        check_results();
        // CMD reads back as zero with no error
        apb_read(`CLA_REG_CMD, rd, err);
        check_err("pslverr", 1'b0, err);
        check_data("CMD", '0, rd);
    endtask

    initial begin
        data_t rd;
        logic  err;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'h02519a3d));
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset values
        check_err("pslverr", 1'b0, pslverr);
        apb_read(`CLA_REG_RESULT, rd, err);
        check_err("pslverr", 1'b0, err);
        check_data("RESULT", '0, rd);
        apb_read(`CLA_REG_FLAGS, rd, err);
        check_err("pslverr", 1'b0, err);
        check_data("FLAGS", '0, rd);

        run_random(1'b0);
        run_random(1'b1);

        // Lookahead boundaries and sign corners
        run_op(32'hFFFF_FFFF, 32'h0000_0001, 1'b0, 1'b0);
        run_op(32'hFFFF_FFFF, 32'h0000_0000, 1'b0, 1'b1);
        run_op(32'h0000_FFFF, 32'h0000_0001, 1'b0, 1'b0);
        run_op(32'h0000_000F, 32'h0000_0001, 1'b0, 1'b0);
        run_op(32'h8000_0000, 32'h0000_0001, 1'b1, 1'b0);
        run_op(32'h7FFF_FFFF, 32'h0000_0001, 1'b0, 1'b0);
        run_op(32'h0000_0000, 32'h0000_0001, 1'b1, 1'b1);
        run_op(32'h8000_0000, 32'h8000_0000, 1'b0, 1'b0);

        check_operands();
        check_bus_errors();

        $display("Test passed");
        $finish;
    end

endmodule

/* src.f */
+incdir+rtl
rtl/cla_pkg.sv
rtl/cla4.sv
rtl/cla16.sv
rtl/cla32.sv
rtl/adder_apb_regs.sv
rtl/adder_apb_top.sv
verif/tb_adder_apb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_adder_apb
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# $fatal in the testbench gives a nonzero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
